/* hp48_bus_pkg.sv */
package hp48_bus_pkg;

        // Bus address, as seen by every device pointer.
        typedef logic [19:0] addr_t;

        // One data nibble on the bus.
        typedef logic [3:0] nibble_t;

        // Bus commands driven by the controller.
        // Codes 9 to 15 are reserved and treated as illegal.
        typedef enum logic [3:0] {
                NOP         = 4'd0,
                PC_READ     = 4'd1,
                DP_READ     = 4'd2,
                PC_WRITE    = 4'd3,
                DP_WRITE    = 4'd4,
                LOAD_PC     = 4'd5,
                LOAD_DP     = 4'd6,
                CONFIGURE   = 4'd7,
                UNCONFIGURE = 4'd8
        } bus_cmd_e;

        // Decoded request from the decode stage to the devices.
        typedef struct packed {
                bus_cmd_e cmd;
                addr_t    address;
                nibble_t  data;
                logic     is_read;
                logic     is_write;
                // Selects the PC pointer instead of DP.
                logic     use_pc;
                logic     load_pc;
                logic     load_dp;
                logic     configure;
                logic     unconfigure;
        } bus_req_t;

        // Reply of one device, one cycle after the request.
        typedef struct packed {
                logic    hit;
                nibble_t data;
                logic    configured;
        } dev_reply_t;

endpackage

/* hp48_bus_decode.sv */
`timescale 1ns/1ps

module hp48_bus_decode (
        input  logic                  clk,
        input  logic                  reset,
        input  hp48_bus_pkg::bus_cmd_e command,
        input  hp48_bus_pkg::addr_t   address,
        input  hp48_bus_pkg::nibble_t nibble_in,
        output hp48_bus_pkg::bus_req_t req,
        output logic                  read_pending,
        output logic                  bus_error
);

        hp48_bus_pkg::bus_req_t next_req;
        logic                   illegal;

        // Classify the command; once the error is set everything becomes NOP.
        always_comb
        begin
                next_req         = '0;
                next_req.cmd     = hp48_bus_pkg::NOP;
                next_req.address = address;
                next_req.data    = nibble_in;
                illegal          = 1'b0;
                if (!bus_error)
                begin
                        next_req.cmd = command;
                        case (command)
                                hp48_bus_pkg::NOP:
                                begin
                                end
                                hp48_bus_pkg::PC_READ:
                                begin
                                        next_req.is_read = 1'b1;
                                        next_req.use_pc  = 1'b1;
                                end
                                hp48_bus_pkg::DP_READ:
                                        next_req.is_read = 1'b1;
                                hp48_bus_pkg::PC_WRITE:
                                begin
                                        next_req.is_write = 1'b1;
                                        next_req.use_pc   = 1'b1;
                                end
                                hp48_bus_pkg::DP_WRITE:
                                        next_req.is_write = 1'b1;
                                hp48_bus_pkg::LOAD_PC:
                                        next_req.load_pc = 1'b1;
                                hp48_bus_pkg::LOAD_DP:
                                        next_req.load_dp = 1'b1;
                                hp48_bus_pkg::CONFIGURE:
                                        next_req.configure = 1'b1;
                                hp48_bus_pkg::UNCONFIGURE:
                                        next_req.unconfigure = 1'b1;
                                default:
                                begin
                                        // Reserved code, forwarded as NOP.
                                        next_req.cmd = hp48_bus_pkg::NOP;
                                        illegal      = 1'b1;
                                end
                        endcase
                end
        end

        always_ff @(posedge clk)
        begin
                if (reset)
                begin
                        req          <= '0;
                        read_pending <= 1'b0;
                        bus_error    <= 1'b0;
                end
                else
                begin
                        req          <= next_req;
                        // Lines up with the device replies one stage later.
                        read_pending <= req.is_read;
                        bus_error    <= bus_error | illegal;
                end
        end

        // At most one command class per request.
        assert property (@(posedge clk) disable iff (reset)
                $onehot0({req.is_read, req.is_write, req.load_pc, req.load_dp,
                          req.configure, req.unconfigure}));

endmodule

/* hp48_bus_ram.sv */
`timescale 1ns/1ps

module hp48_bus_ram #(
        parameter int mem_len = 64
) (
        input  logic                     clk,
        input  logic                     reset,
        input  hp48_bus_pkg::bus_req_t   req,
        input  logic                     chain_in,
        output logic                     chain_out,
        output hp48_bus_pkg::dev_reply_t reply
);

        localparam int idx_w = $clog2(mem_len);

        hp48_bus_pkg::nibble_t mem [0:mem_len-1];

        logic                configured;
        hp48_bus_pkg::addr_t base_addr;
        hp48_bus_pkg::addr_t pc_ptr;
        hp48_bus_pkg::addr_t data_ptr;

        hp48_bus_pkg::addr_t sel_ptr;
        hp48_bus_pkg::addr_t offset;
        logic [idx_w-1:0]    index;
        logic                in_window;
        logic                dev_hit;
        logic                rd_hit;
        logic                wr_hit;

        // The next device in the chain may configure once this one is.
        assign chain_out = configured;

        // Window test on the pointer that belongs to the command.
        assign sel_ptr   = req.use_pc ? pc_ptr : data_ptr;
        assign offset    = sel_ptr - base_addr;
        assign index     = offset[idx_w-1:0];
        // Offset form avoids overflow of base plus length near the top.
        assign in_window = configured && (sel_ptr >= base_addr) &&
                           (offset < hp48_bus_pkg::addr_t'(mem_len));
        assign dev_hit   = in_window && (req.is_read || req.is_write);
        assign rd_hit    = dev_hit && req.is_read;
        assign wr_hit    = dev_hit && req.is_write;

        // Pointers, base and configuration.
        always_ff @(posedge clk)
        begin
                if (reset)
                begin
                        configured <= 1'b0;
                        base_addr  <= '0;
                        pc_ptr     <= '0;
                        data_ptr   <= '0;
                end
                else
                begin
                        // Every device steps its pointer, hit or not.
                        if (req.is_read || req.is_write)
                        begin
                                if (req.use_pc)
                                        pc_ptr <= pc_ptr + 20'd1;
                                else
                                        data_ptr <= data_ptr + 20'd1;
                        end
                        if (req.load_pc)
                                pc_ptr <= req.address;
                        if (req.load_dp)
                                data_ptr <= req.address;
                        // Only the first unconfigured device in the chain takes it.
                        if (req.configure && chain_in && !configured)
                        begin
                                configured <= 1'b1;
                                base_addr  <= req.address;
                        end
                        // Unconfigure releases every device on the bus.
                        if (req.unconfigure)
                                configured <= 1'b0;
                end
        end

        // Nibble array, cleared in one sweep on reset.
        always_ff @(posedge clk)
        begin
                if (reset)
                begin
                        for (int i = 0; i < mem_len; i++)
                                mem[i] <= '0;
                end
                else if (wr_hit)
                        mem[index] <= req.data;
        end

        // Reply for the result stage.
        always_ff @(posedge clk)
        begin
                if (reset)
                        reply <= '0;
                else
                begin
                        reply.hit        <= dev_hit;
                        reply.data       <= rd_hit ? mem[index] : '0;
                        reply.configured <= configured;
                end
        end

        // An unconfigured device stays silent on the next cycle.
        assert property (@(posedge clk) disable iff (reset)
                !configured |=> !reply.hit);

endmodule

/* hp48_bus_result.sv */
`timescale 1ns/1ps

module hp48_bus_result (
        input  logic                     clk,
        input  logic                     reset,
        input  hp48_bus_pkg::dev_reply_t io_reply,
        input  hp48_bus_pkg::dev_reply_t sys_reply,
        input  logic                     read_pending,
        output hp48_bus_pkg::nibble_t    read_nibble,
        output logic                     read_hit,
        output logic                     read_miss
);

        logic                  any_ans;
        hp48_bus_pkg::nibble_t sel_data;

        // A hit from either device answers the read.
        assign any_ans = io_reply.hit | sys_reply.hit;

        always_comb
        begin
                if (io_reply.hit)
                        sel_data = io_reply.data;
                else if (sys_reply.hit)
                        sel_data = sys_reply.data;
                else
                        sel_data = '0;
        end

        always_ff @(posedge clk)
        begin
                if (reset)
                begin
                        read_hit  <= 1'b0;
                        read_miss <= 1'b0;
                end
                else
                begin
                        read_hit  <= read_pending & any_ans;
                        read_miss <= read_pending & ~any_ans;
                end
        end

        // Data path, zero unless a read hit.
        always_ff @(posedge clk)
        begin
                read_nibble <= sel_data;
        end

        // Device windows never overlap.
        assert property (@(posedge clk) disable iff (reset)
                !(io_reply.hit && sys_reply.hit));

endmodule

/* hp48_bus_top.sv */
`timescale 1ns/1ps

module hp48_bus_top #(
        parameter int io_len  = 64,
        parameter int sys_len = 256
) (
        input  logic                   clk,
        input  logic                   reset,
        input  hp48_bus_pkg::bus_cmd_e command,
        input  hp48_bus_pkg::addr_t    address,
        input  hp48_bus_pkg::nibble_t  nibble_in,
        output hp48_bus_pkg::nibble_t  read_nibble,
        output logic                   read_hit,
        output logic                   read_miss,
        output logic                   bus_error
);

        hp48_bus_pkg::bus_req_t   req;
        hp48_bus_pkg::dev_reply_t io_reply;
        hp48_bus_pkg::dev_reply_t sys_reply;
        logic                     read_pending;
        logic                     io_chain_out;

        hp48_bus_decode decode (
                .clk          (clk),
                .reset        (reset),
                .command      (command),
                .address      (address),
                .nibble_in    (nibble_in),
                .req          (req),
                .read_pending (read_pending),
                .bus_error    (bus_error)
        );

        // First in the daisy chain.
        hp48_bus_ram #(
                .mem_len (io_len)
        ) io_ram (
                .clk       (clk),
                .reset     (reset),
                .req       (req),
                .chain_in  (1'b1),
                .chain_out (io_chain_out),
                .reply     (io_reply)
        );

        // Configures only after the I/O RAM.
        hp48_bus_ram #(
                .mem_len (sys_len)
        ) sys_ram (
                .clk       (clk),
                .reset     (reset),
                .req       (req),
                .chain_in  (io_chain_out),
                .chain_out (),
                .reply     (sys_reply)
        );

        hp48_bus_result result (
                .clk          (clk),
                .reset        (reset),
                .io_reply     (io_reply),
                .sys_reply    (sys_reply),
                .read_pending (read_pending),
                .read_nibble  (read_nibble),
                .read_hit     (read_hit),
                .read_miss    (read_miss)
        );

endmodule

/* hp48_bus_checker.sv */
`timescale 1ns/1ps

module hp48_bus_checker #(
        parameter int io_len  = 64,
        parameter int sys_len = 256
) (
        input  logic                   clk,
        input  logic                   reset,
        input  hp48_bus_pkg::bus_cmd_e command,
        input  hp48_bus_pkg::addr_t    address,
        input  hp48_bus_pkg::nibble_t  nibble_in,
        input  hp48_bus_pkg::nibble_t  read_nibble,
        input  logic                   read_hit,
        input  logic                   read_miss,
        input  logic                   bus_error,
        output int                     error_count,
        output int                     check_count
);

        // Expected read result of one command.
        typedef struct packed {
                logic                  hit;
                logic                  miss;
                hp48_bus_pkg::nibble_t data;
        } expect_t;

        // Device 0 is the I/O RAM, device 1 the system RAM.
        logic                  cfg    [0:1];
        hp48_bus_pkg::addr_t   base   [0:1];
        hp48_bus_pkg::addr_t   pc_ptr [0:1];
        hp48_bus_pkg::addr_t   dp_ptr [0:1];
        hp48_bus_pkg::nibble_t mem    [0:1][0:255];
        logic                  err_flag;
        logic                  reset_seen = 1'b1;
        int                    errors = 0;
        int                    checks = 0;
        // Stage 2 is the result due at the outputs in this cycle.
        expect_t               pipe   [0:2];
        expect_t               next_exp;

        assign error_count = errors;
        assign check_count = checks;

        function automatic int dev_len(input int d);
                return (d == 0) ? io_len : sys_len;
        endfunction

        // Window runs from base up to, not including, base plus length.
        function automatic logic in_window(input int d, input hp48_bus_pkg::addr_t ptr);
                logic [20:0] lo;
                logic [20:0] hi;
                lo = {1'b0, base[d]};
                hi = lo + 21'(dev_len(d));
                return cfg[d] && ({1'b0, ptr} >= lo) && ({1'b0, ptr} < hi);
        endfunction

        task automatic reset_model();
                for (int d = 0; d < 2; d++)
                begin
                        cfg[d]    = 1'b0;
                        base[d]   = '0;
                        pc_ptr[d] = '0;
                        dp_ptr[d] = '0;
                        for (int i = 0; i < 256; i++)
                                mem[d][i] = '0;
                end
                err_flag = 1'b0;
                for (int s = 0; s < 3; s++)
                        pipe[s] = '0;
        endtask

        task automatic apply_command(input hp48_bus_pkg::bus_cmd_e cmd,
                                     input hp48_bus_pkg::addr_t addr,
                                     input hp48_bus_pkg::nibble_t nib,
                                     output expect_t res);
                logic                use_pc;
                logic                is_read;
                logic                take_sys;
                hp48_bus_pkg::addr_t ptr;
                hp48_bus_pkg::addr_t off;
                res     = '0;
                use_pc  = (cmd == hp48_bus_pkg::PC_READ) || (cmd == hp48_bus_pkg::PC_WRITE);
                is_read = (cmd == hp48_bus_pkg::PC_READ) || (cmd == hp48_bus_pkg::DP_READ);
                // Once the error is latched every command is dropped.
                if (err_flag)
                        return;
                case (cmd)
                        hp48_bus_pkg::NOP:
                        begin
                        end
                        hp48_bus_pkg::PC_READ, hp48_bus_pkg::DP_READ,
                        hp48_bus_pkg::PC_WRITE, hp48_bus_pkg::DP_WRITE:
                        begin
                                for (int d = 0; d < 2; d++)
                                begin
                                        ptr = use_pc ? pc_ptr[d] : dp_ptr[d];
                                        if (in_window(d, ptr))
                                        begin
                                                off = ptr - base[d];
                                                if (is_read)
                                                begin
                                                        if (!res.hit)
                                                                res.data = mem[d][off[7:0]];
                                                        res.hit = 1'b1;
                                                end
                                                else
                                                        mem[d][off[7:0]] = nib;
                                        end
                                        // Pointer steps in every device.
                                        if (use_pc)
                                                pc_ptr[d] = pc_ptr[d] + 20'd1;
                                        else
                                                dp_ptr[d] = dp_ptr[d] + 20'd1;
                                end
                                res.miss = is_read && !res.hit;
                        end
                        hp48_bus_pkg::LOAD_PC:
                        begin
                                pc_ptr[0] = addr;
                                pc_ptr[1] = addr;
                        end
                        hp48_bus_pkg::LOAD_DP:
                        begin
                                dp_ptr[0] = addr;
                                dp_ptr[1] = addr;
                        end
                        hp48_bus_pkg::CONFIGURE:
                        begin
                                // System RAM sees the chain only behind a configured I/O RAM.
                                take_sys = cfg[0] && !cfg[1];
                                if (!cfg[0])
                                begin
                                        cfg[0]  = 1'b1;
                                        base[0] = addr;
                                end
                                if (take_sys)
                                begin
                                        cfg[1]  = 1'b1;
                                        base[1] = addr;
                                end
                        end
                        hp48_bus_pkg::UNCONFIGURE:
                        begin
                                cfg[0] = 1'b0;
                                cfg[1] = 1'b0;
                        end
                        default:
                                err_flag = 1'b1;
                endcase
        endtask

        task automatic check_flag(input string name, input logic expv, input logic actv);
                checks++;
                if (actv !== expv)
                begin
                        errors++;
                        $display("[ERROR] %0t %s expected %b got %b", $time, name, expv, actv);
                end
        endtask

        task automatic check_nibble(input string name, input hp48_bus_pkg::nibble_t expv,
                                    input hp48_bus_pkg::nibble_t actv);
                checks++;
                if (actv !== expv)
                begin
                        errors++;
                        $display("[ERROR] %0t %s expected %h got %h", $time, name, expv, actv);
                end
        endtask

        // Model steps on the same edge that samples the bus.
        always @(posedge clk)
        begin
                reset_seen = reset;
                if (reset)
                        reset_model();
                else
                begin
                        pipe[2] = pipe[1];
                        pipe[1] = pipe[0];
                        apply_command(command, address, nibble_in, next_exp);
                        pipe[0] = next_exp;
                end
        end

        // Outputs are settled halfway through the cycle.
        always @(negedge clk)
        begin
                if (!reset_seen)
                begin
                        check_flag("read_hit", pipe[2].hit, read_hit);
                        check_flag("read_miss", pipe[2].miss, read_miss);
                        check_flag("bus_error", err_flag, bus_error);
                        if (pipe[2].hit)
                                check_nibble("read_nibble", pipe[2].data, read_nibble);
                end
        end

endmodule

/* tb_hp48_bus.sv */
`timescale 1ns/1ps

module tb_hp48_bus;

        localparam int io_len       = 64;
        localparam int sys_len      = 256;
        localparam int reset_len    = 16;
        localparam int drain_len    = 4;
        localparam int random_pairs = 12;

        // One table row; rst holds reset for that cycle.
        typedef struct packed {
                logic                  rst;
                logic [3:0]            cmd;
                hp48_bus_pkg::addr_t   addr;
                hp48_bus_pkg::nibble_t nib;
        } step_t;

        logic                   clk;
        logic                   reset;
        hp48_bus_pkg::bus_cmd_e command;
        hp48_bus_pkg::addr_t    address;
        hp48_bus_pkg::nibble_t  nibble_in;
        hp48_bus_pkg::nibble_t  read_nibble;
        logic                   read_hit;
        logic                   read_miss;
        logic                   bus_error;
        int                     error_count;
        int                     check_count;
        int                     cycle_count = 0;
        int                     timeout_limit;
        step_t                  steps [$];

        hp48_bus_top #(
                .io_len  (io_len),
                .sys_len (sys_len)
        ) uut (
                .clk         (clk),
                .reset       (reset),
                .command     (command),
                .address     (address),
                .nibble_in   (nibble_in),
                .read_nibble (read_nibble),
                .read_hit    (read_hit),
                .read_miss   (read_miss),
                .bus_error   (bus_error)
        );

        hp48_bus_checker #(
                .io_len  (io_len),
                .sys_len (sys_len)
        ) bus_check (
                .clk         (clk),
                .reset       (reset),
                .command     (command),
                .address     (address),
                .nibble_in   (nibble_in),
                .read_nibble (read_nibble),
                .read_hit    (read_hit),
                .read_miss   (read_miss),
                .bus_error   (bus_error),
                .error_count (error_count),
                .check_count (check_count)
        );

        always #50 clk = ~clk;

        task automatic push_cmd(input logic [3:0] cmd, input hp48_bus_pkg::addr_t addr,
                                input hp48_bus_pkg::nibble_t nib);
                step_t s;
                s.rst  = 1'b0;
                s.cmd  = cmd;
                s.addr = addr;
                s.nib  = nib;
                steps.push_back(s);
        endtask

        task automatic push_reset();
                step_t s;
                s = '0;
                s.rst = 1'b1;
                steps.push_back(s);
        endtask

        task automatic build_table();
                int unsigned         dev;
                int unsigned         off;
                hp48_bus_pkg::addr_t addr;
                hp48_bus_pkg::nibble_t nib;
                // Reads before any configuration miss.
                push_cmd(hp48_bus_pkg::DP_READ, 20'h00000, 4'h0);
                push_cmd(hp48_bus_pkg::PC_READ, 20'h00000, 4'h0);
                // I/O RAM first, then system RAM.
                push_cmd(hp48_bus_pkg::CONFIGURE, 20'h00100, 4'h0);
                push_cmd(hp48_bus_pkg::CONFIGURE, 20'h20000, 4'h0);
                push_cmd(hp48_bus_pkg::LOAD_PC, 20'h00100, 4'h0);
                push_cmd(hp48_bus_pkg::PC_READ, 20'h00000, 4'h0);
                push_cmd(hp48_bus_pkg::LOAD_PC, 20'h20000, 4'h0);
                push_cmd(hp48_bus_pkg::PC_READ, 20'h00000, 4'h0);
                // Write bursts; the last system write runs past the window.
                push_cmd(hp48_bus_pkg::LOAD_DP, 20'h00104, 4'h0);
                push_cmd(hp48_bus_pkg::DP_WRITE, 20'h00000, 4'ha);
                push_cmd(hp48_bus_pkg::DP_WRITE, 20'h00000, 4'h3);
                push_cmd(hp48_bus_pkg::DP_WRITE, 20'h00000, 4'h7);
                push_cmd(hp48_bus_pkg::DP_WRITE, 20'h00000, 4'hc);
                push_cmd(hp48_bus_pkg::LOAD_DP, 20'h200fc, 4'h0);
                push_cmd(hp48_bus_pkg::DP_WRITE, 20'h00000, 4'h5);
                push_cmd(hp48_bus_pkg::DP_WRITE, 20'h00000, 4'he);
                push_cmd(hp48_bus_pkg::DP_WRITE, 20'h00000, 4'h2);
                push_cmd(hp48_bus_pkg::DP_WRITE, 20'h00000, 4'h9);
                push_cmd(hp48_bus_pkg::DP_WRITE, 20'h00000, 4'hf);
                // Read them back in order.
                push_cmd(hp48_bus_pkg::LOAD_PC, 20'h00104, 4'h0);
                push_cmd(hp48_bus_pkg::PC_READ, 20'h00000, 4'h0);
                push_cmd(hp48_bus_pkg::PC_READ, 20'h00000, 4'h0);
                push_cmd(hp48_bus_pkg::PC_READ, 20'h00000, 4'h0);
                push_cmd(hp48_bus_pkg::PC_READ, 20'h00000, 4'h0);
                push_cmd(hp48_bus_pkg::LOAD_PC, 20'h200fc, 4'h0);
                push_cmd(hp48_bus_pkg::PC_READ, 20'h00000, 4'h0);
                push_cmd(hp48_bus_pkg::PC_READ, 20'h00000, 4'h0);
                push_cmd(hp48_bus_pkg::PC_READ, 20'h00000, 4'h0);
                push_cmd(hp48_bus_pkg::PC_READ, 20'h00000, 4'h0);
                push_cmd(hp48_bus_pkg::PC_READ, 20'h00000, 4'h0);
                // PC writes, DP reads, at the top of the I/O window.
                push_cmd(hp48_bus_pkg::LOAD_PC, 20'h0013e, 4'h0);
                push_cmd(hp48_bus_pkg::PC_WRITE, 20'h00000, 4'h9);
                push_cmd(hp48_bus_pkg::PC_WRITE, 20'h00000, 4'h6);
                push_cmd(hp48_bus_pkg::LOAD_DP, 20'h0013e, 4'h0);
                push_cmd(hp48_bus_pkg::DP_READ, 20'h00000, 4'h0);
                push_cmd(hp48_bus_pkg::DP_READ, 20'h00000, 4'h0);
                push_cmd(hp48_bus_pkg::DP_READ, 20'h00000, 4'h0);
                // Outside both windows.
                push_cmd(hp48_bus_pkg::LOAD_DP, 20'h000ff, 4'h0);
                push_cmd(hp48_bus_pkg::DP_READ, 20'h00000, 4'h0);
                push_cmd(hp48_bus_pkg::LOAD_DP, 20'h80000, 4'h0);
                push_cmd(hp48_bus_pkg::DP_READ, 20'h00000, 4'h0);
                // Unconfigure, then the I/O RAM takes the next base.
                push_cmd(hp48_bus_pkg::UNCONFIGURE, 20'h00000, 4'h0);
                push_cmd(hp48_bus_pkg::LOAD_PC, 20'h00104, 4'h0);
                push_cmd(hp48_bus_pkg::PC_READ, 20'h00000, 4'h0);
                push_cmd(hp48_bus_pkg::CONFIGURE, 20'h40000, 4'h0);
                push_cmd(hp48_bus_pkg::LOAD_DP, 20'h40004, 4'h0);
                push_cmd(hp48_bus_pkg::DP_READ, 20'h00000, 4'h0);
                push_cmd(hp48_bus_pkg::LOAD_PC, 20'h20000, 4'h0);
                push_cmd(hp48_bus_pkg::PC_READ, 20'h00000, 4'h0);
                push_cmd(hp48_bus_pkg::CONFIGURE, 20'h50000, 4'h0);
                push_cmd(hp48_bus_pkg::LOAD_PC, 20'h500fc, 4'h0);
                push_cmd(hp48_bus_pkg::PC_READ, 20'h00000, 4'h0);
                push_cmd(hp48_bus_pkg::PC_READ, 20'h00000, 4'h0);
                // Reserved code; the bus goes quiet until reset.
                push_cmd(4'hb, 20'h00000, 4'h0);
                push_cmd(hp48_bus_pkg::LOAD_PC, 20'h40004, 4'h0);
                push_cmd(hp48_bus_pkg::PC_READ, 20'h00000, 4'h0);
                push_cmd(hp48_bus_pkg::DP_READ, 20'h00000, 4'h0);
                push_reset();
                push_reset();
                push_cmd(hp48_bus_pkg::DP_READ, 20'h00000, 4'h0);
                push_cmd(hp48_bus_pkg::CONFIGURE, 20'h01000, 4'h0);
                push_cmd(hp48_bus_pkg::CONFIGURE, 20'h03000, 4'h0);
                // Random write and read pairs inside the windows.
                for (int i = 0; i < random_pairs; i++)
                begin
                        dev = $urandom % 2;
                        off = (dev == 0) ? $urandom % io_len : $urandom % sys_len;
                        addr = ((dev == 0) ? 20'h01000 : 20'h03000) + hp48_bus_pkg::addr_t'(off);
                        nib = hp48_bus_pkg::nibble_t'($urandom);
                        push_cmd(hp48_bus_pkg::LOAD_DP, addr, 4'h0);
                        push_cmd(hp48_bus_pkg::DP_WRITE, 20'h00000, nib);
                        push_cmd(hp48_bus_pkg::LOAD_PC, addr, 4'h0);
                        push_cmd(hp48_bus_pkg::PC_READ, 20'h00000, 4'h0);
                end
        endtask

        task automatic apply_step(input step_t s);
                reset     = s.rst;
                command   = hp48_bus_pkg::bus_cmd_e'(s.cmd);
                address   = s.addr;
                nibble_in = s.nib;
        endtask

        always @(posedge clk)
        begin
                cycle_count = cycle_count + 1;
                if (cycle_count > timeout_limit)
                begin
                        $display("Timeout: no end of test after %0d cycles", timeout_limit);
                        $display("Simulation failed");
                        $finish;
                end
        end

        initial
        begin
                clk       = 1'b0;
                reset     = 1'b1;
                command   = hp48_bus_pkg::NOP;
                address   = '0;
                nibble_in = '0;
                void'($urandom(32'hcd5b31bd));
                build_table();
                timeout_limit = steps.size() + reset_len + 20;
                repeat (reset_len) @(negedge clk);
                reset = 1'b0;
                foreach (steps[i])
                begin
                        apply_step(steps[i]);
                        @(negedge clk);
                end
                reset   = 1'b0;
                command = hp48_bus_pkg::NOP;
                repeat (drain_len) @(negedge clk);
                $display("Checks run: %0d, errors: %0d", check_count, error_count);
                if (error_count == 0)
                        $display("Simulation completed successfully");
                else
                        $display("Simulation failed");
                $finish;
        end

endmodule

/* flist.f */
hp48_bus_pkg.sv
hp48_bus_decode.sv
hp48_bus_ram.sv
hp48_bus_result.sv
hp48_bus_top.sv
hp48_bus_checker.sv
tb_hp48_bus.sv

/* Makefile */
TOP = tb_hp48_bus

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f flist.f -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee sim.log
	grep -q "Simulation completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log
